// ==== hw/core_pkg.sv ====
`default_nettype none

package core_pkg;

    localparam int xlen_default = 32;
    localparam int alen_default = 32;

    // Instruction bits 6 to 2
    typedef enum logic [4:0] {
        OP     = 5'b01100,
        OP_IMM = 5'b00100,
        LUI    = 5'b01101,
        AUIPC  = 5'b00101,
        JAL    = 5'b11011,
        JALR   = 5'b11001,
        BRANCH = 5'b11000
    } opcode_t;

    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    localparam logic [2:0] F3_ADD  = 3'b000;  // Also SUB
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101;  // SRL or SRA
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    typedef enum logic [3:0] {
        EXC_INSTR_ADDR_MISALIGNED = 4'd0,
        EXC_ILLEGAL_INSTR         = 4'd2
    } trap_cause_t;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR, ALU_SRL,
        ALU_SRA, ALU_OR, ALU_AND, ALU_LUI, ALU_AUIPC,
        ALU_ILLEGAL  // Opcode outside both units
    } alu_op_t;

endpackage

`default_nettype wire

// ==== hw/issue_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface issue_if import core_pkg::*; #(
    parameter int XLEN = xlen_default,
    parameter int ALEN = alen_default
) ();
    logic            valid_raw;
    logic            valid;  // Dropped while redirect is high
    logic            is_branch;
    logic            is_alu;
    opcode_t         opcode;
    logic [2:0]      funct3;
    logic            funct7b5;
    logic [4:0]      rd;
    logic [XLEN-1:0] rs1_data;
    logic [XLEN-1:0] rs2_data;
    logic [XLEN-1:0] i_imm;
    logic [XLEN-1:0] b_imm;
    logic [XLEN-1:0] j_imm;
    logic [XLEN-1:0] u_imm;
    logic [ALEN-1:0] addr;
    logic [ALEN-1:0] next_addr;
    alu_op_t         alu_op;

    modport decoder (output valid_raw, valid, is_branch, is_alu, opcode, funct3, funct7b5, rd,
                     rs1_data, rs2_data, i_imm, b_imm, j_imm, u_imm, addr, next_addr, alu_op);
    modport alu (input valid, is_alu, opcode, funct3, funct7b5, rd, rs1_data, rs2_data, i_imm,
                 u_imm, addr, alu_op);
    modport branch (input valid_raw, valid, is_branch, opcode, funct3, rd, rs1_data, rs2_data,
                    i_imm, b_imm, j_imm, addr, next_addr);
endinterface

`default_nettype wire

// ==== hw/instr_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module instr_decode import core_pkg::*; #(
    parameter int XLEN = xlen_default,
    parameter int ALEN = alen_default
) (
    input  wire [31:0]     instr,
    input  wire [ALEN-1:0] instr_addr,
    input  wire            instr_valid,
    input  wire [XLEN-1:0] rs1_data,
    input  wire [XLEN-1:0] rs2_data,
    input  wire            redirect,
    issue_if.decoder       iss
);

    opcode_t    opcode;
    logic [2:0] funct3;
    logic       funct7b5;
    logic       is_branch;
    alu_op_t    reg_op;
    alu_op_t    alu_op;

    assign opcode   = opcode_t'(instr[6:2]);
    assign funct3   = instr[14:12];
    assign funct7b5 = instr[30];

    assign is_branch = opcode inside {JAL, JALR, BRANCH};

    assign iss.valid_raw = instr_valid;
    assign iss.valid     = instr_valid && !redirect;  // Wrong-path instr never issues
    assign iss.is_branch = is_branch;
    assign iss.is_alu    = !is_branch;  // Unknown opcodes land here too
    assign iss.opcode    = opcode;
    assign iss.funct3    = funct3;
    assign iss.funct7b5  = funct7b5;
    assign iss.rd        = instr[11:7];
    assign iss.rs1_data  = rs1_data;
    assign iss.rs2_data  = rs2_data;

    assign iss.i_imm = XLEN'($signed(instr[31:20]));
    assign iss.b_imm = XLEN'($signed({instr[31], instr[7], instr[30:25], instr[11:8], 1'b0}));
    assign iss.j_imm = XLEN'($signed({instr[31], instr[19:12], instr[20], instr[30:21], 1'b0}));
    assign iss.u_imm = XLEN'($signed({instr[31:12], 12'b0}));

    assign iss.addr      = instr_addr;
    assign iss.next_addr = instr_addr + ALEN'(4);
    assign iss.alu_op    = alu_op;

    // OP and OP-IMM share the funct3 map, bit 30 is an immediate bit for ADDI
    always_comb begin
        case (funct3)
            F3_ADD:  reg_op = (opcode == OP && funct7b5) ? ALU_SUB : ALU_ADD;
            F3_SLL:  reg_op = ALU_SLL;
            F3_SLT:  reg_op = ALU_SLT;
            F3_SLTU: reg_op = ALU_SLTU;
            F3_XOR:  reg_op = ALU_XOR;
            F3_SR:   reg_op = funct7b5 ? ALU_SRA : ALU_SRL;
            F3_OR:   reg_op = ALU_OR;
            F3_AND:  reg_op = ALU_AND;
        endcase
    end

    always_comb begin
        case (opcode)
            OP, OP_IMM:        alu_op = reg_op;
            LUI:               alu_op = ALU_LUI;
            AUIPC:             alu_op = ALU_AUIPC;
            JAL, JALR, BRANCH: alu_op = ALU_ADD;  // Ignored, branch unit owns these
            default:           alu_op = ALU_ILLEGAL;
        endcase
    end

endmodule

`default_nettype wire

// ==== hw/exec_alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module exec_alu import core_pkg::*; #(
    parameter int XLEN = xlen_default,
    parameter int ALEN = alen_default
) (
    input  wire             clk,
    input  wire             rst,
    issue_if.alu            iss,
    output logic            alu_valid,
    output logic [4:0]      alu_rd,
    output logic [XLEN-1:0] alu_result,
    output logic            alu_exception
);

    localparam int SHW = $clog2(XLEN);

    logic            issue;
    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] op_b;
    logic [SHW-1:0]  shamt;
    logic [ALEN-1:0] auipc_sum;
    logic [XLEN-1:0] result;
    logic            bad_funct7;
    logic            illegal;

    assign issue     = iss.valid && iss.is_alu;
    assign op_a      = iss.rs1_data;
    assign op_b      = (iss.opcode == OP) ? iss.rs2_data : iss.i_imm;
    assign shamt     = op_b[SHW-1:0];
    assign auipc_sum = iss.addr + ALEN'(iss.u_imm);

    always_comb begin
        case (iss.alu_op)
            ALU_ADD:   result = op_a + op_b;
            ALU_SUB:   result = op_a - op_b;
            ALU_SLL:   result = op_a << shamt;
            ALU_SLT:   result = XLEN'($signed(op_a) < $signed(op_b));
            ALU_SLTU:  result = XLEN'(op_a < op_b);
            ALU_XOR:   result = op_a ^ op_b;
            ALU_SRL:   result = op_a >> shamt;
            ALU_SRA:   result = $signed(op_a) >>> shamt;
            ALU_OR:    result = op_a | op_b;
            ALU_AND:   result = op_a & op_b;
            ALU_LUI:   result = iss.u_imm;
            ALU_AUIPC: result = XLEN'(auipc_sum);
            default:   result = '0;
        endcase
    end

    // Bit 30 may only select SUB, SRA or SRAI
    always_comb begin
        bad_funct7 = 1'b0;
        if (iss.opcode == OP) begin
            bad_funct7 = iss.funct7b5 && iss.funct3 != F3_ADD && iss.funct3 != F3_SR;
        end else if (iss.opcode == OP_IMM) begin
            bad_funct7 = iss.funct7b5 && iss.funct3 == F3_SLL;
        end
    end

    assign illegal = (iss.alu_op == ALU_ILLEGAL) || bad_funct7;

    always_ff @(posedge clk) begin
        if (rst) begin
            alu_valid <= 1'b0;
        end else begin
            alu_valid <= issue;
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            alu_rd        <= iss.rd;
            alu_result    <= result;
            alu_exception <= illegal;
        end
    end

endmodule

`default_nettype wire

// ==== hw/exec_branch.sv ====
`timescale 1ns/1ps
`default_nettype none

module exec_branch import core_pkg::*; #(
    parameter int XLEN = xlen_default,
    parameter int ALEN = alen_default
) (
    input  wire             clk,
    input  wire             rst,
    issue_if.branch         iss,
    output logic            br_valid,
    output logic [4:0]      br_rd,
    output logic [XLEN-1:0] br_result,
    output logic            br_taken,
    output logic            br_exception,
    output trap_cause_t     br_trap_cause,
    output logic            redirect,
    output logic [ALEN-1:0] redirect_pc
);

    logic            issue;
    logic [ALEN-1:0] adder_a;
    logic [ALEN-1:0] adder_b;
    logic [ALEN-1:0] adder_sum;
    logic [ALEN-1:0] target;
    logic            illegal;
    logic            rs_equal;
    logic            rs_less;
    logic            rs_less_u;
    logic            cond;
    logic            taken;
    logic            last_cf;
    logic [ALEN-1:0] last_resolved;

    assign issue = iss.valid && iss.is_branch;

    // One shared target adder
    always_comb begin
        adder_a = iss.addr;
        adder_b = ALEN'(iss.b_imm);
        illegal = 1'b0;
        case (iss.opcode)
            JAL: begin
                adder_b = ALEN'(iss.j_imm);
            end
            JALR: begin
                adder_a = ALEN'(iss.rs1_data);
                adder_b = ALEN'(iss.i_imm);
                illegal = iss.funct3 != 3'b000;
            end
            BRANCH: begin
                illegal = iss.funct3 == 3'b010 || iss.funct3 == 3'b011;
            end
            default: begin
                illegal = 1'b0;
            end
        endcase
    end

    assign adder_sum = adder_a + adder_b;
    assign target    = (iss.opcode == JALR) ? {adder_sum[ALEN-1:1], 1'b0} : adder_sum;

    assign rs_equal  = iss.rs1_data == iss.rs2_data;
    assign rs_less   = $signed(iss.rs1_data) < $signed(iss.rs2_data);
    assign rs_less_u = iss.rs1_data < iss.rs2_data;

    always_comb begin
        case (iss.funct3)
            F3_BEQ:  cond = rs_equal;
            F3_BNE:  cond = !rs_equal;
            F3_BLT:  cond = rs_less;
            F3_BGE:  cond = !rs_less;
            F3_BLTU: cond = rs_less_u;
            F3_BGEU: cond = !rs_less_u;
            default: cond = 1'b0;
        endcase
    end

    assign taken = (iss.opcode == BRANCH) ? cond : 1'b1;  // Jumps always taken

    always_ff @(posedge clk) begin
        if (issue) begin
            br_rd     <= (iss.opcode == BRANCH) ? 5'd0 : iss.rd;  // Bits 11:7 are imm here
            br_result <= XLEN'(iss.next_addr);  // Link value, not the target
            if (illegal) begin
                br_exception  <= 1'b1;
                br_trap_cause <= EXC_ILLEGAL_INSTR;
            end else if (taken && target[0]) begin
                br_exception  <= 1'b1;
                br_trap_cause <= EXC_INSTR_ADDR_MISALIGNED;
            end else begin
                br_exception <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            br_valid <= 1'b0;
            br_taken <= 1'b0;
            last_cf  <= 1'b0;
        end else begin
            br_valid <= issue;
            br_taken <= issue && taken;
            if (iss.valid) begin
                last_cf <= iss.is_branch;
            end
        end
    end

    // Where the next instruction must come from
    always_ff @(posedge clk) begin
        if (issue) begin
            last_resolved <= taken ? target : iss.next_addr;
        end
    end

    // A redirected instr leaves the state alone, so the resend compares the same way
    assign redirect    = iss.valid_raw && last_cf && iss.addr != last_resolved;
    assign redirect_pc = last_resolved;

endmodule

`default_nettype wire

// ==== hw/exec_commit.sv ====
`timescale 1ns/1ps
`default_nettype none

module exec_commit import core_pkg::*; #(
    parameter int XLEN = xlen_default
) (
    input  wire             alu_valid,
    input  wire [4:0]       alu_rd,
    input  wire [XLEN-1:0]  alu_result,
    input  wire             alu_exception,
    input  wire             br_valid,
    input  wire [4:0]       br_rd,
    input  wire [XLEN-1:0]  br_result,
    input  wire             br_taken,
    input  wire             br_exception,
    input  wire [3:0]       br_trap_cause,
    output logic            out_valid,
    output logic            rd_we,
    output logic [4:0]      rd,
    output logic [XLEN-1:0] rd_data,
    output logic            exception,
    output logic [3:0]      trap_cause,
    output logic            branch_taken
);

    // Only one instr in flight, so at most one unit is valid
    always_comb begin
        if (br_valid) begin
            rd         = br_rd;
            rd_data    = br_result;
            exception  = br_exception;
            trap_cause = br_trap_cause;
        end else begin
            rd         = alu_rd;
            rd_data    = alu_result;
            exception  = alu_valid && alu_exception;
            trap_cause = EXC_ILLEGAL_INSTR;  // Only fault the ALU raises
        end
    end

    assign out_valid    = alu_valid || br_valid;
    assign branch_taken = br_valid && br_taken;
    assign rd_we        = out_valid && !exception && rd != 5'd0;  // x0 never written

endmodule

`default_nettype wire

// ==== hw/exec_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module exec_stage import core_pkg::*; #(
    parameter int XLEN = xlen_default,
    parameter int ALEN = alen_default
) (
    input  wire             clk,
    input  wire             rst,
    input  wire             instr_valid,
    input  wire [31:0]      instr,
    input  wire [ALEN-1:0]  instr_addr,
    input  wire [XLEN-1:0]  rs1_data,
    input  wire [XLEN-1:0]  rs2_data,
    output logic            out_valid,
    output logic            rd_we,
    output logic [4:0]      rd,
    output logic [XLEN-1:0] rd_data,
    output logic            exception,
    output logic [3:0]      trap_cause,
    output logic            branch_taken,
    output logic            redirect,
    output logic [ALEN-1:0] redirect_pc
);

    logic            alu_valid;
    logic [4:0]      alu_rd;
    logic [XLEN-1:0] alu_result;
    logic            alu_exception;
    logic            br_valid;
    logic [4:0]      br_rd;
    logic [XLEN-1:0] br_result;
    logic            br_taken;
    logic            br_exception;
    logic [3:0]      br_trap_cause;

    issue_if #(.XLEN(XLEN), .ALEN(ALEN)) iss ();

    instr_decode #(.XLEN(XLEN), .ALEN(ALEN)) i_instr_decode (
        .instr       (instr),
        .instr_addr  (instr_addr),
        .instr_valid (instr_valid),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .redirect    (redirect),
        .iss         (iss.decoder)
    );

    exec_alu #(.XLEN(XLEN), .ALEN(ALEN)) i_exec_alu (
        .clk           (clk),
        .rst           (rst),
        .iss           (iss.alu),
        .alu_valid     (alu_valid),
        .alu_rd        (alu_rd),
        .alu_result    (alu_result),
        .alu_exception (alu_exception)
    );

    exec_branch #(.XLEN(XLEN), .ALEN(ALEN)) i_exec_branch (
        .clk           (clk),
        .rst           (rst),
        .iss           (iss.branch),
        .br_valid      (br_valid),
        .br_rd         (br_rd),
        .br_result     (br_result),
        .br_taken      (br_taken),
        .br_exception  (br_exception),
        .br_trap_cause (br_trap_cause),
        .redirect      (redirect),
        .redirect_pc   (redirect_pc)
    );

    exec_commit #(.XLEN(XLEN)) i_exec_commit (
        .alu_valid     (alu_valid),
        .alu_rd        (alu_rd),
        .alu_result    (alu_result),
        .alu_exception (alu_exception),
        .br_valid      (br_valid),
        .br_rd         (br_rd),
        .br_result     (br_result),
        .br_taken      (br_taken),
        .br_exception  (br_exception),
        .br_trap_cause (br_trap_cause),
        .out_valid     (out_valid),
        .rd_we         (rd_we),
        .rd            (rd),
        .rd_data       (rd_data),
        .exception     (exception),
        .trap_cause    (trap_cause),
        .branch_taken  (branch_taken)
    );

endmodule

`default_nettype wire

// ==== verification/exec_stage_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module exec_stage_tb import core_pkg::*; ();

    localparam int stim_cycles = 10 + 207 + 15 + 8 + 11 + 9 + 9;  // Reset plus each test
    localparam int cycle_limit = 2 * stim_cycles + 100;

    typedef struct packed {
        logic        we;
        logic        wb;        // Produces a value
        logic [4:0]  rd;
        logic [31:0] data;
        logic        exc;
        logic [3:0]  cause;
        logic        taken;
        logic        cf;        // Control-flow instr
        logic [31:0] resolved;  // Where the next instr must come from
    } expect_t;

    logic        clk = 1'b0;
    logic        rst;
    logic        instr_valid;
    logic [31:0] instr;
    logic [31:0] instr_addr;
    logic [31:0] rs1_data;
    logic [31:0] rs2_data;
    logic        out_valid;
    logic        rd_we;
    logic [4:0]  rd;
    logic [31:0] rd_data;
    logic        exception;
    logic [3:0]  trap_cause;
    logic        branch_taken;
    logic        redirect;
    logic [31:0] redirect_pc;

    expect_t     q[$];
    expect_t     head;
    logic        prev_cf = 1'b0;
    logic [31:0] prev_resolved = '0;
    logic [31:0] pc = '0;
    int          seed = 32'h960e;
    int          cycles = 0;
    int          checks = 0;
    int          errors = 0;
    int          start_errors = 0;
    int          tests = 0;

    exec_stage #(.XLEN(xlen_default), .ALEN(alen_default)) i_exec_stage (
        .clk          (clk),
        .rst          (rst),
        .instr_valid  (instr_valid),
        .instr        (instr),
        .instr_addr   (instr_addr),
        .rs1_data     (rs1_data),
        .rs2_data     (rs2_data),
        .out_valid    (out_valid),
        .rd_we        (rd_we),
        .rd           (rd),
        .rd_data      (rd_data),
        .exception    (exception),
        .trap_cause   (trap_cause),
        .branch_taken (branch_taken),
        .redirect     (redirect),
        .redirect_pc  (redirect_pc)
    );

    always #5 clk = ~clk;

    // Register fields are don't-care since operands come in directly
    function automatic logic [31:0] r_type(input logic b30, input logic [2:0] f3,
                                           input logic [4:0] rd_sel);
        return {1'b0, b30, 5'b0, 5'd2, 5'd1, f3, rd_sel, OP, 2'b11};
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [2:0] f3,
                                           input logic [4:0] rd_sel, input logic [4:0] opc);
        return {imm, 5'd1, f3, rd_sel, opc, 2'b11};
    endfunction

    function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [2:0] f3);
        return {imm[12], imm[10:5], 5'd2, 5'd1, f3, imm[4:1], imm[11], BRANCH, 2'b11};
    endfunction

    function automatic logic [31:0] j_type(input logic [20:0] imm, input logic [4:0] rd_sel);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd_sel, JAL, 2'b11};
    endfunction

    function automatic expect_t expected_outcome(input logic [31:0] ins,
                                                 input logic [31:0] addr,
                                                 input logic [31:0] a, input logic [31:0] b);
        expect_t     e;
        logic [4:0]  opc;
        logic [2:0]  f3;
        logic        b30;
        logic [31:0] imm_i;
        logic [31:0] op2;
        logic [31:0] target;
        logic        cond;
        opc        = ins[6:2];
        f3         = ins[14:12];
        b30        = ins[30];
        imm_i      = {{20{ins[31]}}, ins[31:20]};
        op2        = (opc == OP) ? b : imm_i;
        e          = '0;
        e.rd       = ins[11:7];
        e.resolved = addr + 32'd4;
        case (opc)
            OP, OP_IMM: begin
                e.wb = 1'b1;
                case (f3)
                    F3_ADD:  e.data = (opc == OP && b30) ? a - op2 : a + op2;
                    F3_SLL:  e.data = a << op2[4:0];
                    F3_SLT:  e.data = {31'b0, $signed(a) < $signed(op2)};
                    F3_SLTU: e.data = {31'b0, a < op2};
                    F3_XOR:  e.data = a ^ op2;
                    F3_SR: begin
                        if (b30) begin
                            e.data = $signed(a) >>> op2[4:0];
                        end else begin
                            e.data = a >> op2[4:0];
                        end
                    end
                    F3_OR:   e.data = a | op2;
                    default: e.data = a & op2;
                endcase
                // In OP-IMM bit 30 is an immediate bit, except for SLLI
                e.exc = (opc == OP) ? b30 && f3 != F3_ADD && f3 != F3_SR : b30 && f3 == F3_SLL;
            end
            LUI, AUIPC: begin
                e.wb   = 1'b1;
                e.data = {ins[31:12], 12'b0} + ((opc == AUIPC) ? addr : 32'd0);
            end
            JAL, JALR, BRANCH: begin
                e.cf   = 1'b1;
                e.wb   = opc != BRANCH;
                e.data = addr + 32'd4;  // Link value
                if (opc == JAL) begin
                    target = addr + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
                end else if (opc == JALR) begin
                    target = (a + imm_i) & ~32'd1;
                end else begin
                    target = addr + {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
                end
                case (f3)
                    F3_BEQ:  cond = a == b;
                    F3_BNE:  cond = a != b;
                    F3_BLT:  cond = $signed(a) < $signed(b);
                    F3_BGE:  cond = $signed(a) >= $signed(b);
                    F3_BLTU: cond = a < b;
                    F3_BGEU: cond = a >= b;
                    default: cond = 1'b0;
                endcase
                e.taken = (opc == BRANCH) ? cond : 1'b1;
                if ((opc == JALR && f3 != 3'd0) || (opc == BRANCH && f3 inside {3'd2, 3'd3})) begin
                    e.exc   = 1'b1;
                    e.cause = EXC_ILLEGAL_INSTR;
                end else if (e.taken && target[0]) begin
                    e.exc   = 1'b1;
                    e.cause = EXC_INSTR_ADDR_MISALIGNED;
                end
                if (e.taken) begin
                    e.resolved = target;
                end
            end
            default: e.exc = 1'b1;  // No unit claims it
        endcase
        if (e.exc && !e.cf) begin
            e.cause = EXC_ILLEGAL_INSTR;
        end
        e.wb = e.wb && !e.exc;
        e.we = e.wb && e.rd != 5'd0;
        return e;
    endfunction

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Fail at %0t: %s expected %0h, got %0h", $time, name, exp, act);
        end
    endtask

    task automatic note_error(input string msg);
        errors++;
        $display("Error at %0t: %s", $time, msg);
    endtask

    task automatic issue_instr(input logic [31:0] ins, input logic [31:0] addr,
                               input logic [31:0] a, input logic [31:0] b);
        expect_t e;
        logic    wrong_path;
        @(negedge clk);
        instr_valid = 1'b1;
        instr       = ins;
        instr_addr  = addr;
        rs1_data    = a;
        rs2_data    = b;
        e           = expected_outcome(ins, addr, a, b);
        wrong_path  = prev_cf && addr != prev_resolved;
        #1;
        check("redirect", 32'(wrong_path), 32'(redirect));
        if (wrong_path) begin
            check("redirect_pc", prev_resolved, redirect_pc);  // Dropped instr leaves state alone
        end else begin
            q.push_back(e);
            prev_cf       = e.cf;
            prev_resolved = e.resolved;
            pc            = e.resolved;
        end
    endtask

    task automatic close_test(input string name);
        @(negedge clk);
        instr_valid = 1'b0;
        repeat (2) @(posedge clk);
        tests++;
        $display("%s done, %0d errors", name, errors - start_errors);
        start_errors = errors;
    endtask

    task automatic drive_alu_mix();
        logic [31:0] r;
        logic [2:0]  f3;
        logic [4:0]  rd_sel;
        logic [11:0] imm;
        for (int i = 0; i < 200; i++) begin
            r      = $random(seed);
            f3     = r[2:0];
            rd_sel = (i % 40 == 0) ? 5'd0 : r[7:3];
            if (r[8]) begin
                issue_instr(r_type(r[9] && (f3 == F3_ADD || f3 == F3_SR), f3, rd_sel), pc,
                            $random(seed), $random(seed));
            end else begin
                case (f3)
                    F3_SLL:  imm = {7'b0, r[14:10]};
                    F3_SR:   imm = {1'b0, r[9], 5'b0, r[14:10]};  // SRLI or SRAI
                    default: imm = r[26:15];
                endcase
                issue_instr(i_type(imm, f3, rd_sel, OP_IMM), pc, $random(seed), 32'd0);
            end
        end
        for (int i = 0; i < 2; i++) begin
            r = $random(seed);
            issue_instr({r[31:12], r[4:0], LUI, 2'b11}, pc, 32'd0, 32'd0);
            issue_instr({r[31:12], 5'(i), AUIPC, 2'b11}, pc, 32'd0, 32'd0);  // rd 0 then 1
        end
        close_test("ALU operations");
    endtask

    task automatic sweep_branches();
        logic [31:0] r;
        logic [31:0] a;
        for (int f = 0; f < 8; f++) begin
            if (f == 2 || f == 3) begin
                continue;
            end
            r = $random(seed);
            a = $random(seed);
            issue_instr(b_type({r[12:1], 1'b0}, 3'(f)), pc, a, $random(seed));
            issue_instr(b_type({r[24:13], 1'b0}, 3'(f)), pc, a, a);
        end
        close_test("Conditional branches");
    endtask

    task automatic chase_jumps();
        logic [31:0] r;
        logic [31:0] a;
        for (int i = 0; i < 2; i++) begin
            r = $random(seed);
            issue_instr(j_type({r[20:1], 1'b0}, r[25:21]), pc, 32'd0, 32'd0);
            a    = $random(seed);
            a[0] = !r[20];  // Odd sum, so bit 0 of the target must be cleared
            issue_instr(i_type(r[31:20], 3'd0, 5'd1, JALR), pc, a, 32'd0);
        end
        issue_instr(i_type(12'd1, F3_ADD, 5'd3, OP_IMM), pc, 32'd5, 32'd0);
        close_test("JAL and JALR");
    endtask

    task automatic raise_exceptions();
        issue_instr(i_type(12'd16, 3'd1, 5'd4, JALR), pc, 32'h1000, 32'd0);
        issue_instr(b_type(13'd8, 3'd2), pc, 32'd1, 32'd1);
        issue_instr(b_type(13'd8, 3'd3), pc, 32'd1, 32'd1);
        issue_instr(32'h0000_0283, pc, 32'd0, 32'd0);  // LW has no unit in this stage
        issue_instr(r_type(1'b1, F3_XOR, 5'd5), pc, 32'd3, 32'd4);  // Bit 30 on XOR
        issue_instr(i_type(12'h401, F3_SLL, 5'd5, OP_IMM), pc, 32'd3, 32'd0);  // Bit 30 on SLLI
        issue_instr(j_type(21'd64, 5'd1), pc | 32'd1, 32'd0, 32'd0);
        issue_instr(i_type(12'd0, F3_ADD, 5'd2, OP_IMM), pc, 32'd0, 32'd0);
        close_test("Exceptions");
    endtask

    task automatic force_redirects();
        logic [31:0] br;
        pc = 32'h0000_2000;
        br = pc;
        issue_instr(b_type(13'd64, F3_BEQ), br, 32'd7, 32'd7);
        issue_instr(i_type(12'd1, F3_ADD, 5'd1, OP_IMM), br + 32'd4, 32'd0, 32'd0);
        check("redirect", 32'd1, 32'(redirect));
        issue_instr(i_type(12'd1, F3_ADD, 5'd1, OP_IMM), br + 32'd64, 32'd0, 32'd0);
        br = pc;
        issue_instr(b_type(13'd64, F3_BNE), br, 32'd7, 32'd7);  // Not taken
        issue_instr(i_type(12'd2, F3_ADD, 5'd1, OP_IMM), br + 32'd64, 32'd0, 32'd0);
        check("redirect", 32'd1, 32'(redirect));
        issue_instr(i_type(12'd2, F3_ADD, 5'd1, OP_IMM), br + 32'd4, 32'd0, 32'd0);
        close_test("Redirect");
    endtask

    task automatic reset_midrun();
        issue_instr(j_type(21'd256, 5'd1), pc, 32'd0, 32'd0);
        @(negedge clk);
        rst     = 1'b1;  // JAL stays valid on the bus, off its own target
        prev_cf = 1'b0;
        repeat (2) begin
            @(posedge clk);
            #1;
            check("out_valid", 32'd0, 32'(out_valid));
            check("branch_taken", 32'd0, 32'(branch_taken));
            check("redirect", 32'd0, 32'(redirect));
        end
        @(negedge clk);
        instr_valid = 1'b0;
        rst         = 1'b0;
        issue_instr(i_type(12'd9, F3_ADD, 5'd6, OP_IMM), 32'h0000_0400, 32'd1, 32'd0);
        issue_instr(i_type(12'd3, F3_OR, 5'd7, OP_IMM), pc, 32'd4, 32'd0);
        close_test("Reset");
    endtask

    // One result per issued instr, one edge later
    always @(posedge clk) begin
        #1;
        if (out_valid === 1'b1 && q.size() == 0) begin
            note_error("out_valid high with no instruction pending");
        end else if (out_valid !== 1'b1 && q.size() != 0) begin
            note_error("out_valid missing for an issued instruction");
            void'(q.pop_front());
        end else if (out_valid === 1'b1) begin
            head = q.pop_front();
            check("rd_we", 32'(head.we), 32'(rd_we));
            check("exception", 32'(head.exc), 32'(exception));
            check("branch_taken", 32'(head.taken), 32'(branch_taken));
            if (head.exc) begin
                check("trap_cause", 32'(head.cause), 32'(trap_cause));
            end
            if (head.wb) begin
                check("rd", 32'(head.rd), 32'(rd));
                check("rd_data", head.data, rd_data);
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("Timeout: run went past %0d cycles", cycle_limit);
            $display("TEST FAIL");
            $finish;
        end
    end

    initial begin
        rst         = 1'b1;
        instr_valid = 1'b0;
        instr       = '0;
        instr_addr  = '0;
        rs1_data    = '0;
        rs2_data    = '0;
        repeat (10) @(negedge clk);
        rst = 1'b0;
        drive_alu_mix();
        sweep_branches();
        chase_jumps();
        raise_exceptions();
        force_redirects();
        reset_midrun();
        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb.f ====
hw/core_pkg.sv
hw/issue_if.sv
hw/instr_decode.sv
hw/exec_alu.sv
hw/exec_branch.sv
hw/exec_commit.sv
hw/exec_stage.sv
verification/exec_stage_tb.sv

// ==== Makefile ====
TOP = exec_stage_tb

sim:
	verilator --binary --timing -f tb.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "TEST PASS" sim.log

clean:
	rm -rf obj_dir sim.log
